// ==== files.f ====
hdl/opf_pkg.sv
hdl/opf_decoder.sv
hdl/opf_regfile.sv
hdl/opf_bypass.sv
hdl/opf_issue_reg.sv
hdl/opf_top.sv
dv/opf_tb.sv

// ==== dv/opf_tb.sv ====
// Testbench for the operand-fetch stage, DATA_WIDTH fixed at 32
// Inputs change 2 ns after the rising edge, so checks at the edge see stable values
// Expected operands come from a shadow register model updated with each cycle's writes
// Concurrent assertions compare the issue outputs one cycle after each strobe
// Needs a simulator with concurrent assertion support

`timescale 1ns/100ps

module opf_tb;

  localparam int DW = 32;

  // Test lengths in cycles for the timeout limit
  localparam int RESET_CYCLES = 8;
  localparam int FILL_CYCLES  = 31;
  localparam int RAND_CYCLES  = 320;
  localparam int FMT_PER_OPC  = 24;
  localparam int NUM_FMT_OPC  = 14;
  localparam int SHORT_CYCLES = 60;
  localparam int TOTAL_CYCLES = RESET_CYCLES + FILL_CYCLES + RAND_CYCLES
                              + FMT_PER_OPC * NUM_FMT_OPC + SHORT_CYCLES;
  localparam int MAX_CYCLES   = (TOTAL_CYCLES * 3) / 2;

  logic                  clk;
  logic                  rst_n;
  opf_pkg::instr_t       instr;
  logic                  instr_valid;
  opf_pkg::reg_addr_t    waddr_a;
  logic [DW-1:0]         wdata_a;
  logic                  we_a;
  opf_pkg::reg_addr_t    waddr_b;
  logic [DW-1:0]         wdata_b;
  logic                  we_b;
  logic                  opnd_valid_o;
  logic [DW-1:0]         opnd_a_o;
  logic [DW-1:0]         opnd_b_o;
  logic [DW-1:0]         opnd_c_o;
  opf_pkg::reg_addr_t    dest_o;
  logic                  dest_we_o;

  // Reference state
  logic [DW-1:0]         shadow [32];
  logic                  exp_valid;
  logic [DW-1:0]         exp_a;
  logic [DW-1:0]         exp_b;
  logic [DW-1:0]         exp_c;
  opf_pkg::reg_addr_t    exp_dest;
  logic                  exp_we;
  // Expected outputs after the issue register edge
  logic                  exp_valid_q;
  logic [DW-1:0]         exp_a_q;
  logic [DW-1:0]         exp_b_q;
  logic [DW-1:0]         exp_c_q;
  opf_pkg::reg_addr_t    exp_dest_q;
  logic                  exp_we_q;

  integer seed = 87;
  int     err_cnt = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     test_err_start = 0;
  int     cycle_cnt = 0;

  opf_top #(
    .DATA_WIDTH (DW)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .waddr_a_i     (waddr_a),
    .wdata_a_i     (wdata_a),
    .we_a_i        (we_a),
    .waddr_b_i     (waddr_b),
    .wdata_b_i     (wdata_b),
    .we_b_i        (we_b),
    .opnd_valid_o  (opnd_valid_o),
    .opnd_a_o      (opnd_a_o),
    .opnd_b_o      (opnd_b_o),
    .opnd_c_o      (opnd_c_o),
    .dest_o        (dest_o),
    .dest_we_o     (dest_we_o)
  );

  always #20 clk = ~clk;

  // Run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Expected outputs move with the DUT output register
  always @(posedge clk)
  begin
    exp_valid_q <= exp_valid;
    exp_a_q     <= exp_a;
    exp_b_q     <= exp_b;
    exp_c_q     <= exp_c;
    exp_dest_q  <= exp_dest;
    exp_we_q    <= exp_we;
  end

  task automatic report_mismatch(input string sig, input logic [DW-1:0] exp,
                                 input logic [DW-1:0] act);
    $display("** Error at %0t: %s expected %h, got %h", $time, sig, exp, act);
    err_cnt++;
  endtask

  // Operand usage per format
  function automatic logic is_r4(input opf_pkg::opcode_t opc);
    return opc inside {opf_pkg::OPC_MADD, opf_pkg::OPC_MSUB,
                       opf_pkg::OPC_NMSUB, opf_pkg::OPC_NMADD};
  endfunction

  function automatic logic reads_rs1(input opf_pkg::opcode_t opc);
    return is_r4(opc) || (opc inside {opf_pkg::OPC_OP, opf_pkg::OPC_OP_IMM,
      opf_pkg::OPC_LOAD, opf_pkg::OPC_STORE, opf_pkg::OPC_BRANCH, opf_pkg::OPC_JALR});
  endfunction

  function automatic logic reads_rs2(input opf_pkg::opcode_t opc);
    return is_r4(opc) || (opc inside {opf_pkg::OPC_OP, opf_pkg::OPC_STORE,
                                      opf_pkg::OPC_BRANCH});
  endfunction

  // Any known format with a destination
  function automatic logic has_dest(input opf_pkg::opcode_t opc);
    return is_r4(opc) || (opc inside {opf_pkg::OPC_OP, opf_pkg::OPC_OP_IMM,
      opf_pkg::OPC_LOAD, opf_pkg::OPC_JALR, opf_pkg::OPC_LUI, opf_pkg::OPC_AUIPC,
      opf_pkg::OPC_JAL});
  endfunction

  function automatic logic [DW-1:0] read_shadow(input opf_pkg::reg_addr_t a);
    return (a == '0) ? '0 : shadow[a];
  endfunction

  function automatic opf_pkg::instr_t make_instr(input opf_pkg::opcode_t opc,
    input opf_pkg::reg_addr_t rd, input opf_pkg::reg_addr_t rs1,
    input opf_pkg::reg_addr_t rs2, input opf_pkg::reg_addr_t rs3);
    return {rs3, 2'b01, rs2, rs1, 3'b101, rd, opc};
  endfunction

  // One cycle of stimulus; writes land at the next edge,
  // so the strobe expects the state after they are applied
  task automatic drive(input opf_pkg::instr_t ins, input logic v,
    input opf_pkg::reg_addr_t wa, input logic [DW-1:0] da, input logic wea,
    input opf_pkg::reg_addr_t wb, input logic [DW-1:0] db, input logic web);
    opf_pkg::opcode_t opc;
    opc = ins[6:0];
    @(posedge clk);
    #2;
    instr       = ins;
    instr_valid = v;
    waddr_a     = wa;
    wdata_a     = da;
    we_a        = wea;
    waddr_b     = wb;
    wdata_b     = db;
    we_b        = web;
    // Port A first so port B wins on the same register
    if (wea && wa != '0)
      shadow[wa] = da;
    if (web && wb != '0)
      shadow[wb] = db;
    exp_valid = v;
    if (v)
    begin
      exp_a    = reads_rs1(opc) ? read_shadow(ins[19:15]) : '0;
      exp_b    = reads_rs2(opc) ? read_shadow(ins[24:20]) : '0;
      exp_c    = is_r4(opc) ? read_shadow(ins[31:27]) : '0;
      exp_dest = ins[11:7];
      exp_we   = has_dest(opc) && (ins[11:7] != '0);
    end
  endtask

  task automatic drive_rand(input opf_pkg::instr_t ins, input logic v);
    logic [DW-1:0] da;
    logic [DW-1:0] db;
    logic [DW-1:0] ctl;
    da  = $random(seed);
    db  = $random(seed);
    ctl = $random(seed);
    drive(ins, v, ctl[4:0], da, ctl[5], ctl[12:8], db, ctl[13]);
  endtask

  task automatic idle();
    drive('0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
  endtask

  // Two idle cycles let the last strobe reach its check
  task automatic end_test(input string name);
    int errs;
    idle();
    idle();
    errs = err_cnt - test_err_start;
    if (errs == 0)
      tests_passed++;
    else
      tests_failed++;
    $display("Test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    test_err_start = err_cnt;
  endtask

  // Checks
  a_reset: assert property (@(posedge clk) !rst_n |-> (!opnd_valid_o && !dest_we_o
      && opnd_a_o == '0 && opnd_b_o == '0 && opnd_c_o == '0))
    else
    begin
      $display("Outputs not cleared while reset is asserted, at %0t", $time);
      err_cnt++;
    end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
      opnd_valid_o == exp_valid_q)
    else report_mismatch("opnd_valid_o", $sampled(exp_valid_q), $sampled(opnd_valid_o));

  a_opnd_a: assert property (@(posedge clk) disable iff (!rst_n)
      opnd_valid_o |-> opnd_a_o == exp_a_q)
    else report_mismatch("opnd_a_o", $sampled(exp_a_q), $sampled(opnd_a_o));

  a_opnd_b: assert property (@(posedge clk) disable iff (!rst_n)
      opnd_valid_o |-> opnd_b_o == exp_b_q)
    else report_mismatch("opnd_b_o", $sampled(exp_b_q), $sampled(opnd_b_o));

  a_opnd_c: assert property (@(posedge clk) disable iff (!rst_n)
      opnd_valid_o |-> opnd_c_o == exp_c_q)
    else report_mismatch("opnd_c_o", $sampled(exp_c_q), $sampled(opnd_c_o));

  a_dest_we: assert property (@(posedge clk) disable iff (!rst_n)
      dest_we_o == (exp_valid_q && exp_we_q))
    else report_mismatch("dest_we_o", $sampled(exp_valid_q && exp_we_q),
                         $sampled(dest_we_o));

  a_dest: assert property (@(posedge clk) disable iff (!rst_n)
      (opnd_valid_o && exp_we_q) |-> dest_o == exp_dest_q)
    else report_mismatch("dest_o", $sampled(exp_dest_q), $sampled(dest_o));

  initial
  begin
    opf_pkg::opcode_t fmt_opc [NUM_FMT_OPC];
    opf_pkg::opcode_t opc;
    logic [DW-1:0]    r;
    opf_pkg::instr_t  ins;
    fmt_opc = '{opf_pkg::OPC_OP, opf_pkg::OPC_OP_IMM, opf_pkg::OPC_LOAD,
                opf_pkg::OPC_STORE, opf_pkg::OPC_BRANCH, opf_pkg::OPC_JAL,
                opf_pkg::OPC_JALR, opf_pkg::OPC_LUI, opf_pkg::OPC_AUIPC,
                opf_pkg::OPC_MADD, opf_pkg::OPC_MSUB, opf_pkg::OPC_NMSUB,
                opf_pkg::OPC_NMADD, 7'b1111111};
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    waddr_a     = '0;
    wdata_a     = '0;
    we_a        = 1'b0;
    waddr_b     = '0;
    wdata_b     = '0;
    we_b        = 1'b0;
    exp_valid   = 1'b0;
    exp_a       = '0;
    exp_b       = '0;
    exp_c       = '0;
    exp_dest    = '0;
    exp_we      = 1'b0;
    exp_valid_q = 1'b0;
    exp_a_q     = '0;
    exp_b_q     = '0;
    exp_c_q     = '0;
    exp_dest_q  = '0;
    exp_we_q    = 1'b0;
    for (int i = 0; i < 32; i++)
      shadow[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Single strobe and then back-to-back strobes on the reset register state
    drive(make_instr(opf_pkg::OPC_OP, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, '0, '0, 1'b0,
          '0, '0, 1'b0);
    idle();
    for (int i = 0; i < 4; i++)
      drive(make_instr(opf_pkg::OPC_MADD, 5'(i + 4), 5'(i), 5'(i + 8), 5'(i + 16)),
            1'b1, '0, '0, 1'b0, '0, '0, 1'b0);
    end_test("reset_and_pulses");

    // Fill every register, then random strobes with random writes
    for (int i = 1; i < 32; i++)
    begin
      r = $random(seed);
      drive('0, 1'b0, 5'(i), r, 1'b1, 5'(32 - i), ~r, 1'b1);
    end
    for (int i = 0; i < RAND_CYCLES; i++)
    begin
      r   = $random(seed);
      opc = r[0] ? opf_pkg::OPC_OP : fmt_opc[9 + r[2:1]];
      ins = make_instr(opc, r[11:7], r[19:15], r[24:20], r[31:27]);
      drive_rand(ins, r[3] | r[4]);
    end
    end_test("random_op_r4");

    // Writes in the strobe cycle reach the operands
    drive(make_instr(opf_pkg::OPC_OP, 5'd3, 5'd5, 5'd6, 5'd0), 1'b1,
          5'd5, 32'hA5A5_0001, 1'b1, 5'd6, 32'h5A5A_0002, 1'b1);
    drive(make_instr(opf_pkg::OPC_MADD, 5'd7, 5'd6, 5'd5, 5'd5), 1'b1,
          5'd5, 32'h1111_2222, 1'b1, 5'd0, '0, 1'b0);
    drive(make_instr(opf_pkg::OPC_NMADD, 5'd8, 5'd5, 5'd6, 5'd7), 1'b1,
          5'd0, '0, 1'b0, 5'd7, 32'h3333_4444, 1'b1);
    end_test("same_cycle_forward");

    // Both ports write one register and port B data must win
    drive(make_instr(opf_pkg::OPC_OP, 5'd2, 5'd9, 5'd9, 5'd0), 1'b1,
          5'd9, 32'hAAAA_AAAA, 1'b1, 5'd9, 32'hBBBB_BBBB, 1'b1);
    drive(make_instr(opf_pkg::OPC_MSUB, 5'd2, 5'd9, 5'd10, 5'd9), 1'b1,
          5'd10, 32'hCCCC_0000, 1'b1, 5'd10, 32'hDDDD_0000, 1'b1);
    drive(make_instr(opf_pkg::OPC_OP, 5'd2, 5'd9, 5'd10, 5'd0), 1'b1,
          '0, '0, 1'b0, '0, '0, 1'b0);
    end_test("dual_write_priority");

    // x0 writes dropped and x0 reads zero
    drive(make_instr(opf_pkg::OPC_NMSUB, 5'd0, 5'd0, 5'd0, 5'd0), 1'b1,
          5'd0, 32'hFFFF_FFFF, 1'b1, 5'd0, 32'h1234_5678, 1'b1);
    drive(make_instr(opf_pkg::OPC_OP, 5'd4, 5'd0, 5'd0, 5'd0), 1'b1,
          5'd0, 32'hDEAD_BEEF, 1'b1, '0, '0, 1'b0);
    drive(make_instr(opf_pkg::OPC_MADD, 5'd0, 5'd0, 5'd11, 5'd0), 1'b1,
          '0, '0, 1'b0, '0, '0, 1'b0);
    end_test("x0_handling");

    // Every format with rd of x0 on every fourth strobe
    for (int k = 0; k < NUM_FMT_OPC; k++)
    begin
      for (int i = 0; i < FMT_PER_OPC; i++)
      begin
        r   = $random(seed);
        ins = make_instr(fmt_opc[k], (i % 4 == 0) ? 5'd0 : r[11:7], r[19:15],
                         r[24:20] | 5'd1, r[31:27] | 5'd1);
        drive_rand(ins, 1'b1);
      end
    end
    end_test("format_handling");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== hdl/opf_top.sv ====
// Operand-fetch stage: decode, register read, bypass, issue register
// Latency from instr_valid_i to opnd_valid_o is one cycle
// Writes enabled in the strobe cycle are forwarded to the operands
// DATA_WIDTH is 32 or 64; register index width is fixed at 5

`timescale 1ns/100ps

module opf_top #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Instruction in
  input  opf_pkg::instr_t       instr_i,
  input  logic                  instr_valid_i,
  // Writeback port A
  input  opf_pkg::reg_addr_t    waddr_a_i,
  input  logic [DATA_WIDTH-1:0] wdata_a_i,
  input  logic                  we_a_i,
  // Writeback port B, wins on the same register
  input  opf_pkg::reg_addr_t    waddr_b_i,
  input  logic [DATA_WIDTH-1:0] wdata_b_i,
  input  logic                  we_b_i,
  // Issued operands
  output logic                  opnd_valid_o,
  output logic [DATA_WIDTH-1:0] opnd_a_o,
  output logic [DATA_WIDTH-1:0] opnd_b_o,
  output logic [DATA_WIDTH-1:0] opnd_c_o,
  output opf_pkg::reg_addr_t    dest_o,
  output logic                  dest_we_o
);

  opf_pkg::reg_idx_t     idx;
  logic                  dec_valid;
  logic [DATA_WIDTH-1:0] rf_a;
  logic [DATA_WIDTH-1:0] rf_b;
  logic [DATA_WIDTH-1:0] rf_c;
  logic [DATA_WIDTH-1:0] byp_a;
  logic [DATA_WIDTH-1:0] byp_b;
  logic [DATA_WIDTH-1:0] byp_c;

  opf_decoder i_decoder (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .idx_o         (idx),
    .valid_o       (dec_valid)
  );

  opf_regfile #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (idx.rs1),
    .raddr_b_i (idx.rs2),
    .raddr_c_i (idx.rs3),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .rdata_c_o (rf_c),
    .waddr_a_i (waddr_a_i),
    .waddr_b_i (waddr_b_i),
    .wdata_a_i (wdata_a_i),
    .wdata_b_i (wdata_b_i),
    .we_a_i    (we_a_i),
    .we_b_i    (we_b_i)
  );

  // Same write ports fanned out to the bypass
  opf_bypass #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_bypass (
    .idx_i     (idx),
    .rf_a_i    (rf_a),
    .rf_b_i    (rf_b),
    .rf_c_i    (rf_c),
    .waddr_a_i (waddr_a_i),
    .waddr_b_i (waddr_b_i),
    .wdata_a_i (wdata_a_i),
    .wdata_b_i (wdata_b_i),
    .we_a_i    (we_a_i),
    .we_b_i    (we_b_i),
    .opnd_a_o  (byp_a),
    .opnd_b_o  (byp_b),
    .opnd_c_o  (byp_c)
  );

  opf_issue_reg #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_issue_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (dec_valid),
    .opnd_a_i     (byp_a),
    .opnd_b_i     (byp_b),
    .opnd_c_i     (byp_c),
    .rd_i         (idx.rd),
    .rd_we_i      (idx.rd_we),
    .opnd_valid_o (opnd_valid_o),
    .opnd_a_o     (opnd_a_o),
    .opnd_b_o     (opnd_b_o),
    .opnd_c_o     (opnd_c_o),
    .dest_o       (dest_o),
    .dest_we_o    (dest_we_o)
  );

endmodule

// ==== hdl/opf_issue_reg.sv ====
// Output register of the operand-fetch stage
// Loads on every valid strobe, no back-pressure
// Fields hold their value between strobes; only the valid flag drops
// dest_we_o is only high together with opnd_valid_o

`timescale 1ns/100ps

module opf_issue_reg #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] opnd_a_i,
  input  logic [DATA_WIDTH-1:0] opnd_b_i,
  input  logic [DATA_WIDTH-1:0] opnd_c_i,
  input  opf_pkg::reg_addr_t    rd_i,
  input  logic                  rd_we_i,
  output logic                  opnd_valid_o,
  output logic [DATA_WIDTH-1:0] opnd_a_o,
  output logic [DATA_WIDTH-1:0] opnd_b_o,
  output logic [DATA_WIDTH-1:0] opnd_c_o,
  output opf_pkg::reg_addr_t    dest_o,
  output logic                  dest_we_o
);

  logic valid_q;
  logic rd_we_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q  <= 1'b0;
      rd_we_q  <= 1'b0;
      opnd_a_o <= '0;
      opnd_b_o <= '0;
      opnd_c_o <= '0;
      dest_o   <= '0;
    end
    else
    begin
      // One-cycle pulse per strobe
      valid_q <= valid_i;
      if (valid_i)
      begin
        opnd_a_o <= opnd_a_i;
        opnd_b_o <= opnd_b_i;
        opnd_c_o <= opnd_c_i;
        dest_o   <= rd_i;
        rd_we_q  <= rd_we_i;
      end
    end
  end

  assign opnd_valid_o = valid_q;
  // Stale write flag masked once the pulse ends
  assign dest_we_o    = valid_q && rd_we_q;

  // Every field of a strobe shows up together with the valid pulse
  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i |=> (opnd_valid_o && (opnd_a_o == $past(opnd_a_i))
      && (opnd_b_o == $past(opnd_b_i)) && (opnd_c_o == $past(opnd_c_i))
      && (dest_o == $past(rd_i)) && (dest_we_o == $past(rd_we_i))))
    else $error("opf_issue_reg: strobe not loaded into the output register");

endmodule

// ==== hdl/opf_bypass.sv ====
// Same-cycle writeback forwarding for the three source operands
// Combinational; priority matches the register file (B over A)
// so a forwarded value equals what lands in the register file
// x0 is never forwarded

`timescale 1ns/100ps

module opf_bypass #(
  parameter int DATA_WIDTH = 32
) (
  input  opf_pkg::reg_idx_t     idx_i,
  // Raw register file reads
  input  logic [DATA_WIDTH-1:0] rf_a_i,
  input  logic [DATA_WIDTH-1:0] rf_b_i,
  input  logic [DATA_WIDTH-1:0] rf_c_i,
  // Writeback ports as the register file sees them
  input  opf_pkg::reg_addr_t    waddr_a_i,
  input  opf_pkg::reg_addr_t    waddr_b_i,
  input  logic [DATA_WIDTH-1:0] wdata_a_i,
  input  logic [DATA_WIDTH-1:0] wdata_b_i,
  input  logic                  we_a_i,
  input  logic                  we_b_i,
  // Corrected operands
  output logic [DATA_WIDTH-1:0] opnd_a_o,
  output logic [DATA_WIDTH-1:0] opnd_b_o,
  output logic [DATA_WIDTH-1:0] opnd_c_o
);

  opf_pkg::reg_addr_t    raddr  [3];
  logic [DATA_WIDTH-1:0] rf_val [3];
  logic [DATA_WIDTH-1:0] opnd   [3];
  logic [2:0]            hit_a;
  logic [2:0]            hit_b;

  // Operand slots 0 to 2 carry rs1, rs2 and rs3
  assign raddr[0]  = idx_i.rs1;
  assign raddr[1]  = idx_i.rs2;
  assign raddr[2]  = idx_i.rs3;
  assign rf_val[0] = rf_a_i;
  assign rf_val[1] = rf_b_i;
  assign rf_val[2] = rf_c_i;

  always_comb
  begin
    for (int k = 0; k < 3; k++)
    begin
      hit_b[k] = we_b_i && (waddr_b_i == raddr[k]) && (raddr[k] != '0);
      hit_a[k] = we_a_i && (waddr_a_i == raddr[k]) && (raddr[k] != '0);
      if (hit_b[k])
        opnd[k] = wdata_b_i;
      else if (hit_a[k])
        opnd[k] = wdata_a_i;
      else
        opnd[k] = rf_val[k];
    end
  end

  assign opnd_a_o = opnd[0];
  assign opnd_b_o = opnd[1];
  assign opnd_c_o = opnd[2];

  // An operand read from x0 is zero and never takes write data
  always_comb
  begin
    for (int k = 0; k < 3; k++)
    begin
      assert final ((raddr[k] != '0) || (opnd[k] == '0))
        else $error("opf_bypass: nonzero operand for x0 on slot %0d", k);
    end
  end

endmodule

// ==== hdl/opf_regfile.sv ====
// Behavioral register file, three read ports and two write ports
// Reads are combinational and show the stored value only;
// same-cycle forwarding is done outside, in the bypass
// Port B wins when both ports write the same register
// x0 has no storage and always reads zero

`timescale 1ns/100ps

module opf_regfile #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Read ports
  input  opf_pkg::reg_addr_t    raddr_a_i,
  input  opf_pkg::reg_addr_t    raddr_b_i,
  input  opf_pkg::reg_addr_t    raddr_c_i,
  output logic [DATA_WIDTH-1:0] rdata_a_o,
  output logic [DATA_WIDTH-1:0] rdata_b_o,
  output logic [DATA_WIDTH-1:0] rdata_c_o,
  // Write ports
  input  opf_pkg::reg_addr_t    waddr_a_i,
  input  opf_pkg::reg_addr_t    waddr_b_i,
  input  logic [DATA_WIDTH-1:0] wdata_a_i,
  input  logic [DATA_WIDTH-1:0] wdata_b_i,
  input  logic                  we_a_i,
  input  logic                  we_b_i
);

  localparam int NUM_WORDS = 32;

  // Storage for x1..x31 only
  logic [DATA_WIDTH-1:0]                rf_q [1:NUM_WORDS-1];
  // Full read view with x0 tied to zero
  logic [NUM_WORDS-1:0][DATA_WIDTH-1:0] rf_rd;
  logic [NUM_WORDS-1:1]                 we_a_dec;
  logic [NUM_WORDS-1:1]                 we_b_dec;

  // One-hot write enables per word
  always_comb
  begin
    for (int i = 1; i < NUM_WORDS; i++)
    begin
      we_a_dec[i] = we_a_i && (waddr_a_i == opf_pkg::reg_addr_t'(i));
      we_b_dec[i] = we_b_i && (waddr_b_i == opf_pkg::reg_addr_t'(i));
    end
  end

  for (genvar i = 1; i < NUM_WORDS; i++)
  begin : g_word
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        rf_q[i] <= '0;
      end
      // Port B first to match the bypass priority
      else if (we_b_dec[i])
      begin
        rf_q[i] <= wdata_b_i;
      end
      else if (we_a_dec[i])
      begin
        rf_q[i] <= wdata_a_i;
      end
    end
  end

  always_comb
  begin
    rf_rd[0] = '0;
    for (int i = 1; i < NUM_WORDS; i++)
    begin
      rf_rd[i] = rf_q[i];
    end
  end

  // Combinational reads
  assign rdata_a_o = rf_rd[raddr_a_i];
  assign rdata_b_o = rf_rd[raddr_b_i];
  assign rdata_c_o = rf_rd[raddr_c_i];

  // Port B data is what read port A shows in the next cycle
  a_wr_b_read: assert property (@(posedge clk) disable iff (!rst_n)
    (we_b_i && (waddr_b_i != '0)) |=>
      ((raddr_a_i != $past(waddr_b_i)) || (rdata_a_o == $past(wdata_b_i))))
    else $error("opf_regfile: port B write not seen on the next read");

endmodule

// ==== hdl/opf_decoder.sv ====
// Register field decode for the operand-fetch stage
// Purely combinational, no pipeline state
// Unknown opcodes give all-zero indices and no destination write
// instr_valid_i must be driven to a known level from time zero

`timescale 1ns/100ps

module opf_decoder (
  input  opf_pkg::instr_t   instr_i,
  input  logic              instr_valid_i,
  output opf_pkg::reg_idx_t idx_o,
  output logic              valid_o
);

  opf_pkg::opcode_t   opcode;
  opf_pkg::reg_addr_t rd_field;
  logic               use_rs1;
  logic               use_rs2;
  logic               use_rs3;
  logic               has_rd;

  assign opcode   = instr_i[6:0];
  assign rd_field = instr_i[11:7];

  // Which register fields each format actually reads or writes
  always_comb
  begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rs3 = 1'b0;
    has_rd  = 1'b0;
    case (opcode)
      opf_pkg::OPC_OP:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        has_rd  = 1'b1;
      end
      // I-type, operand B stays x0
      opf_pkg::OPC_OP_IMM, opf_pkg::OPC_LOAD, opf_pkg::OPC_JALR:
      begin
        use_rs1 = 1'b1;
        has_rd  = 1'b1;
      end
      // S and B type, no destination
      opf_pkg::OPC_STORE, opf_pkg::OPC_BRANCH:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      // U and J type, destination only
      opf_pkg::OPC_LUI, opf_pkg::OPC_AUIPC, opf_pkg::OPC_JAL:
      begin
        has_rd = 1'b1;
      end
      opf_pkg::OPC_MADD, opf_pkg::OPC_MSUB, opf_pkg::OPC_NMSUB, opf_pkg::OPC_NMADD:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rs3 = 1'b1;
        has_rd  = 1'b1;
      end
      default:
      begin
        // Unknown opcode, everything stays x0
        has_rd = 1'b0;
      end
    endcase
  end

  // Unused fields forced to x0
  assign idx_o.rs1   = use_rs1 ? instr_i[19:15] : '0;
  assign idx_o.rs2   = use_rs2 ? instr_i[24:20] : '0;
  assign idx_o.rs3   = use_rs3 ? instr_i[31:27] : '0;
  assign idx_o.rd    = has_rd  ? rd_field       : '0;
  // Writes to x0 are dropped here already
  assign idx_o.rd_we = has_rd && (rd_field != '0);

  // Strobe passes straight through
  assign valid_o = instr_valid_i;

  // Strobe must never float, it drives the issue register valid flag
  always_comb
  begin
    assert final (!$isunknown(instr_valid_i))
      else $error("opf_decoder: instr_valid_i is unknown");
  end

endmodule

// ==== hdl/opf_pkg.sv ====
// Shared types and constants for the operand-fetch stage
// Register index width is fixed at 5 by the RISC-V ISA
// Only the major opcodes that the decoder tells apart are listed here
// Data width is not defined here; it is a parameter of each module

package opf_pkg;

  // Register index, x0..x31
  typedef logic [4:0]  reg_addr_t;

  // Raw 32-bit instruction word
  typedef logic [31:0] instr_t;

  // Major opcode field, instr[6:0]
  typedef logic [6:0]  opcode_t;

  // Base integer opcodes
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  // R4 formats, the only users of rs3
  localparam opcode_t OPC_MADD   = 7'b1000011;
  localparam opcode_t OPC_MSUB   = 7'b1000111;
  localparam opcode_t OPC_NMSUB  = 7'b1001011;
  localparam opcode_t OPC_NMADD  = 7'b1001111;

  // Decoded register indices, 21 bits
  // Unused source fields are x0, so they read zero
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rs3;
    reg_addr_t rd;
    logic      rd_we;
  } reg_idx_t;

endpackage
